//--- compile.f
lsu_pkg.sv
lsu_beat_if.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_wb_master.sv
lsu_seq.sv
lsu_top.sv
tb_wb_mem.sv
tb_lsu.sv

//--- lsu_beat_if.sv
`timescale 1ns/1ps

// One bus cycle between the sequencer and the Wishbone master
interface lsu_beat_if import lsu_pkg::*;
#(
  parameter int ADDR_W = 32
);

  logic                  beat_req;   // Single cycle pulse, master must be idle
  logic [ADDR_W-1:0]     adr;        // Word aligned byte address
  logic [LSU_BE_W-1:0]   sel;        // Byte enables
  logic                  we;         // Write cycle
  logic [LSU_DATA_W-1:0] wdat;       // Store data, already on its lanes

  logic                  beat_done;  // Single cycle pulse per request
  logic [LSU_DATA_W-1:0] rdat;       // Valid with beat_done
  logic                  err;        // Valid with beat_done

  modport seq
  (
    output beat_req, adr, sel, we, wdat,
    input  beat_done, rdat, err
  );

  modport master
  (
    input  beat_req, adr, sel, we, wdat,
    output beat_done, rdat, err
  );

endinterface

//--- lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [1:0]            offset_i,    // Byte offset of the access
  input  lsu_ctx_t              ctx_i,
  input  logic                  hold_i,      // First beat of a split load is done
  input  logic [LSU_DATA_W-1:0] rdat_i,      // Data of the current beat
  output logic [LSU_DATA_W-1:0] rdata_o      // Aligned and extended load result
);

  logic [LSU_DATA_W-1:0] held_q;    // Data of the first beat
  logic [LSU_DATA_W-1:0] word_asm;  // Word put together from both beats
  logic [15:0]           half_raw;
  logic [7:0]            byte_raw;

  // Holding register for the lower part of a split load
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      held_q <= '0;
    else if (hold_i)
      held_q <= rdat_i;
  end

  //////////////////////////////////////////////////
  // Field selection
  //////////////////////////////////////////////////

  // Low bytes sit above the offset in the held word, high bytes at the bottom of the new one
  always_comb
  begin
    case (offset_i)
      2'b00: word_asm = rdat_i;
      2'b01: word_asm = {rdat_i[7:0],  held_q[31:8]};
      2'b10: word_asm = {rdat_i[15:0], held_q[31:16]};
      default: word_asm = {rdat_i[23:0], held_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offset_i)
      2'b00: half_raw = rdat_i[15:0];
      2'b01: half_raw = rdat_i[23:8];
      2'b10: half_raw = rdat_i[31:16];
      default: half_raw = {rdat_i[7:0], held_q[31:24]};  // Split halfword
    endcase
  end

  assign byte_raw = rdat_i[{offset_i, 3'b000} +: 8];  // Lane at the offset

  //////////////////////////////////////////////////
  // Extension
  //////////////////////////////////////////////////

  always_comb
  begin
    case (ctx_i.size)
      LSU_BYTE: rdata_o = {{24{ctx_i.sign_ext & byte_raw[7]}}, byte_raw};
      LSU_HALF: rdata_o = {{16{ctx_i.sign_ext & half_raw[15]}}, half_raw};
      default:  rdata_o = word_asm;
    endcase
  end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int LSU_DATA_W = 32;              // Data bus width, byte lane logic is built for 32
  localparam int LSU_BE_W   = LSU_DATA_W / 8;  // One enable per byte lane

  //////////////////////////////////////////////////
  // Access size and context
  //////////////////////////////////////////////////

  // Access size, encoded as in the core's LSU type field
  typedef enum logic [1:0]
  {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Access in flight, the byte offset travels in the address
  typedef struct packed
  {
    lsu_size_e size;      // Byte, halfword or word
    logic      sign_ext;  // Sign extend loaded bytes and halfwords
    logic      we;        // Store when set
    logic      two_beat;  // Misaligned, split over two bus cycles
  } lsu_ctx_t;

endpackage

//--- lsu_seq.sv
`timescale 1ns/1ps

module lsu_seq import lsu_pkg::*;
#(
  parameter int ADDR_W = 32
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Core request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic [ADDR_W-1:0]     req_addr_i,
  input  logic                  req_we_i,
  input  lsu_size_e             req_size_i,
  input  logic                  req_sign_ext_i,
  input  logic [LSU_DATA_W-1:0] req_wdata_i,
  // Core response
  output logic                  rsp_valid_o,
  output logic [LSU_DATA_W-1:0] rsp_rdata_o,
  output logic                  rsp_err_o,
  output logic [ADDR_W-1:0]     rsp_addr_o,
  // Aligners
  input  logic                  two_beat_i,
  input  logic [LSU_BE_W-1:0]   sel_i,
  input  logic [LSU_DATA_W-1:0] wdat_i,
  input  logic [LSU_DATA_W-1:0] rdata_i,
  output logic [1:0]            offset_o,
  output lsu_ctx_t              ctx_o,
  output logic                  second_o,
  output logic                  hold_o,
  output logic [LSU_DATA_W-1:0] wdata_o,    // Latched store data
  lsu_beat_if.seq               beat
);

  typedef enum logic [1:0] {S_IDLE, S_FIRST, S_SECOND, S_RESP} seq_state_e;

  seq_state_e            state_q, state_d;
  logic                  req_q;        // Beat request pulse
  logic                  accept;
  logic                  need_second;
  logic [ADDR_W-1:0]     addr_q;       // Request byte address
  lsu_ctx_t              ctx_q;
  logic [LSU_DATA_W-1:0] wdata_q;
  logic [LSU_DATA_W-1:0] rsp_rdata_q;
  logic                  rsp_err_q;
  logic [ADDR_W-3:0]     word_adr;     // Word index of the current beat

  assign req_ready_o = (state_q == S_IDLE) || (state_q == S_RESP);  // Response cycle accepts too
  assign accept      = req_valid_i && req_ready_o;
  // Second cycle only when the first one went through
  assign need_second = (state_q == S_FIRST) && beat.beat_done && ctx_q.two_beat && !beat.err;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE, S_RESP: state_d = accept ? S_FIRST : S_IDLE;
      S_FIRST:
      begin
        if (beat.beat_done)
          state_d = need_second ? S_SECOND : S_RESP;
      end
      default:
      begin
        if (beat.beat_done)
          state_d = S_RESP;  // Last beat in
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= S_IDLE;
      req_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      req_q   <= accept || need_second;  // Beat issued the cycle after
    end
  end

  // Access context and response data
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q            <= req_addr_i;
      wdata_q           <= req_wdata_i;
      ctx_q.size        <= req_size_i;
      ctx_q.sign_ext    <= req_sign_ext_i;
      ctx_q.we          <= req_we_i;
      ctx_q.two_beat    <= 1'b0;
    end
    else if (req_q && !second_o)
      ctx_q.two_beat <= two_beat_i;  // Aligner decides on the latched access
    if (beat.beat_done)
    begin
      rsp_rdata_q <= rdata_i;        // Last beat wins
      rsp_err_q   <= beat.err;
    end
  end

  //////////////////////////////////////////////////
  // Beat and response outputs
  //////////////////////////////////////////////////

  assign second_o = (state_q == S_SECOND);
  assign word_adr = addr_q[ADDR_W-1:2] + {{(ADDR_W-3){1'b0}}, second_o};  // Next word on beat two

  assign beat.beat_req = req_q;
  assign beat.adr      = {word_adr, 2'b00};
  assign beat.sel      = sel_i;
  assign beat.we       = ctx_q.we;
  assign beat.wdat     = wdat_i;

  assign offset_o = addr_q[1:0];
  assign ctx_o    = ctx_q;
  assign wdata_o  = wdata_q;
  assign hold_o   = (state_q == S_FIRST) && beat.beat_done && ctx_q.two_beat && !ctx_q.we;

  assign rsp_valid_o = (state_q == S_RESP);
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_addr_o  = addr_q;

endmodule

//--- lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*;
(
  input  logic [1:0]            offset_i,    // Byte offset in the word
  input  lsu_ctx_t              ctx_i,
  input  logic                  second_i,    // Second bus cycle of a split access
  input  logic [LSU_DATA_W-1:0] wdata_i,     // Store data, right justified
  output logic [LSU_BE_W-1:0]   sel_o,
  output logic [LSU_DATA_W-1:0] wdat_o,
  output logic                  two_beat_o
);

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  always_comb
  begin
    case (ctx_i.size)
      LSU_BYTE: sel_o = 4'b0001 << offset_i;         // One lane at the offset
      LSU_HALF:
      begin
        if (second_i)
          sel_o = 4'b0001;                           // Upper byte spills into lane 0
        else if (offset_i == 2'b11)
          sel_o = 4'b1000;                           // Lower byte only, rest follows
        else
          sel_o = 4'b0011 << offset_i;
      end
      LSU_WORD:
      begin
        if (second_i)
          sel_o = ~(4'b1111 << offset_i);            // Lanes below the offset
        else
          sel_o = 4'b1111 << offset_i;               // Lanes from the offset upward
      end
      default: sel_o = '0;                           // Illegal size, no lanes
    endcase
  end

  // Rotate left so byte 0 of the data lands on lane offset
  always_comb
  begin
    case (offset_i)
      2'b00: wdat_o = wdata_i;
      2'b01: wdat_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10: wdat_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdat_o = {wdata_i[7:0], wdata_i[31:8]};
    endcase
  end

  // Access crosses a word boundary
  assign two_beat_o = ((ctx_i.size == LSU_WORD) && (offset_i != 2'b00)) ||
                      ((ctx_i.size == LSU_HALF) && (offset_i == 2'b11));

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*;
#(
  parameter int ADDR_W = 32
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Core side
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic [ADDR_W-1:0]     req_addr_i,
  input  logic                  req_we_i,
  input  lsu_size_e             req_size_i,
  input  logic                  req_sign_ext_i,
  input  logic [LSU_DATA_W-1:0] req_wdata_i,
  output logic                  rsp_valid_o,
  output logic [LSU_DATA_W-1:0] rsp_rdata_o,
  output logic                  rsp_err_o,
  output logic [ADDR_W-1:0]     rsp_addr_o,
  // Wishbone classic
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [ADDR_W-1:0]     wb_adr_o,
  output logic [LSU_BE_W-1:0]   wb_sel_o,
  output logic [LSU_DATA_W-1:0] wb_dat_o,
  input  logic [LSU_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i
);

  logic [1:0]            offset;
  lsu_ctx_t              ctx;
  logic                  second;
  logic                  hold;
  logic                  two_beat;
  logic [LSU_BE_W-1:0]   sel;
  logic [LSU_DATA_W-1:0] wdata;   // Latched store data
  logic [LSU_DATA_W-1:0] wdat;    // Store data on its lanes
  logic [LSU_DATA_W-1:0] rdata;   // Aligned load result

  lsu_beat_if #(.ADDR_W(ADDR_W)) beat_if ();

  lsu_seq #(.ADDR_W(ADDR_W)) u_seq
  (
    .clk, .rst_n,
    .req_valid_i, .req_ready_o, .req_addr_i, .req_we_i, .req_size_i,
    .req_sign_ext_i, .req_wdata_i,
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o, .rsp_addr_o,
    .two_beat_i (two_beat), .sel_i (sel), .wdat_i (wdat), .rdata_i (rdata),
    .offset_o (offset), .ctx_o (ctx), .second_o (second), .hold_o (hold),
    .wdata_o (wdata),
    .beat (beat_if.seq)
  );

  lsu_store_align u_store_align
  (
    .offset_i (offset), .ctx_i (ctx), .second_i (second), .wdata_i (wdata),
    .sel_o (sel), .wdat_o (wdat), .two_beat_o (two_beat)
  );

  lsu_load_align u_load_align
  (
    .clk, .rst_n,
    .offset_i (offset), .ctx_i (ctx), .hold_i (hold), .rdat_i (beat_if.rdat),
    .rdata_o (rdata)
  );

  lsu_wb_master #(.ADDR_W(ADDR_W)) u_wb_master
  (
    .clk, .rst_n,
    .beat (beat_if.master),
    .wb_dat_i, .wb_ack_i, .wb_err_i,
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o
  );

endmodule

//--- lsu_wb_master.sv
`timescale 1ns/1ps

module lsu_wb_master import lsu_pkg::*;
#(
  parameter int ADDR_W = 32
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  lsu_beat_if.master            beat,
  input  logic [LSU_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [ADDR_W-1:0]     wb_adr_o,
  output logic [LSU_BE_W-1:0]   wb_sel_o,
  output logic [LSU_DATA_W-1:0] wb_dat_o
);

  typedef enum logic {WB_IDLE, WB_ACTIVE} wb_state_e;

  wb_state_e             state_q;
  logic                  done_q;   // Registered end of cycle
  logic                  term;     // Slave ends the cycle
  logic                  err_q;
  logic [LSU_DATA_W-1:0] rdat_q;

  assign term = wb_ack_i | wb_err_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= WB_IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= (state_q == WB_ACTIVE) && term;  // One pulse, the cycle after ack or err
      if ((state_q == WB_IDLE) && beat.beat_req)
        state_q <= WB_ACTIVE;
      else if ((state_q == WB_ACTIVE) && term)
        state_q <= WB_IDLE;                      // Cyc and stb fall next cycle
    end
  end

  // Bus fields held stable for the whole cycle
  always_ff @(posedge clk)
  begin
    if ((state_q == WB_IDLE) && beat.beat_req)
    begin
      wb_adr_o <= beat.adr;
      wb_sel_o <= beat.sel;
      wb_we_o  <= beat.we;
      wb_dat_o <= beat.wdat;
    end
    if ((state_q == WB_ACTIVE) && term)
    begin
      rdat_q <= wb_dat_i;  // Capture read data at the ack
      err_q  <= wb_err_i;
    end
  end

  assign wb_cyc_o = (state_q == WB_ACTIVE);
  assign wb_stb_o = (state_q == WB_ACTIVE);  // Classic, no idle cycles inside a cycle

  assign beat.beat_done = done_q;
  assign beat.rdat      = rdat_q;
  assign beat.err       = err_q;

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*;
();

  localparam int ADDR_W    = 32;
  localparam int RST_CYC   = 16;
  localparam int N_ALIGNED = 24;  // 8 single beat cases, store and two loads each
  localparam int N_SPLIT   = 12;  // 4 split cases, store and two loads each
  localparam int N_ERROR   = 4;
  localparam int N_RANDOM  = 40;
  localparam int N_OPS     = N_ALIGNED + N_SPLIT + N_ERROR + N_RANDOM;
  localparam int MAX_CYC   = RST_CYC + 20 * N_OPS;  // Two slow beats plus sequencing per op

  logic              clk, rst_n;
  logic              req_valid_i, req_ready_o, req_we_i, req_sign_ext_i;
  logic [ADDR_W-1:0] req_addr_i;
  lsu_size_e         req_size_i;
  logic [31:0]       req_wdata_i;
  logic              rsp_valid_o, rsp_err_o;
  logic [31:0]       rsp_rdata_o;
  logic [ADDR_W-1:0] rsp_addr_o;
  logic              wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i, wb_err_i;
  logic [ADDR_W-1:0] wb_adr_o;
  logic [3:0]        wb_sel_o;
  logic [31:0]       wb_dat_o, wb_dat_i;

  integer      seed;
  int          cycles = 0;
  int          err_cnt = 0;
  int          acc_cnt = 0;
  int          resp_cnt = 0;
  int          tests_run = 0;
  logic [7:0]  ref_mem [256];   // Byte model of the slave memory

  // Expectations of the access in flight
  logic        pending, exp_we, exp_err;
  int          exp_beats, beats_seen;
  logic [31:0] exp_addr, exp_rdata, exp_wdat;
  logic [31:0] exp_adr [2];
  logic [3:0]  exp_sel [2];
  logic [1:0]  acc_off;
  int          acc_n;
  // Bus fields seen while waiting for the slave
  logic        stb_wait, hold_we;
  logic [31:0] hold_adr, hold_dat;
  logic [3:0]  hold_sel;

  lsu_top #(.ADDR_W(ADDR_W)) u_dut
  (
    .clk, .rst_n,
    .req_valid_i, .req_ready_o, .req_addr_i, .req_we_i, .req_size_i,
    .req_sign_ext_i, .req_wdata_i,
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o, .rsp_addr_o,
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o,
    .wb_dat_i, .wb_ack_i, .wb_err_i
  );

  tb_wb_mem #(.ADDR_W(ADDR_W), .SEED(32'h9fc16173)) u_mem
  (
    .clk, .rst_n,
    .cyc_i (wb_cyc_o), .stb_i (wb_stb_o), .we_i (wb_we_o), .adr_i (wb_adr_o),
    .sel_i (wb_sel_o), .dat_i (wb_dat_o), .dat_o (wb_dat_i),
    .ack_o (wb_ack_i), .err_o (wb_err_i)
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  function automatic int size_bytes(lsu_size_e size);
    case (size)
      LSU_BYTE: return 1;
      LSU_HALF: return 2;
      default:  return 4;
    endcase
  endfunction

  // Byte k sits at offset+k, anything past lane 3 belongs to the next word
  function automatic logic [3:0] beat_lanes(logic [1:0] off, int n, bit second);
    logic [3:0] m;
    int p;
    m = '0;
    for (int k = 0; k < n; k++)
    begin
      p = int'(off) + k;
      if ((p >= 4) == second)
        m[p % 4] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [31:0] lane_data(logic [1:0] off, logic [31:0] wdata);
    logic [31:0] d;
    for (int k = 0; k < 4; k++)
      d[((int'(off) + k) % 4) * 8 +: 8] = wdata[k * 8 +: 8];  // Byte k lands on its lane
    return d;
  endfunction

  function automatic logic [31:0] load_value(logic [7:0] a, int n, logic sext);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
      v[k * 8 +: 8] = ref_mem[8'(a + k)];
    if (sext && (n < 4) && v[n * 8 - 1])
      for (int k = n; k < 4; k++)
        v[k * 8 +: 8] = 8'hff;  // Fill with the sign
    return v;
  endfunction

  task automatic value_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    err_cnt++;
    $display("FAIL %0t ns %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic rule_broken(input string what);
    err_cnt++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      assert (!wb_cyc_o && !wb_stb_o && !rsp_valid_o && req_ready_o)
        else rule_broken("DUT outputs not idle in reset");
      pending    <= 1'b0;
      beats_seen <= 0;
      stb_wait   <= 1'b0;
    end
    else
    begin
      // Classic cycle, fields frozen until the slave answers
      if (stb_wait)
      begin
        assert (wb_cyc_o) else rule_broken("wb_cyc_o dropped before ack or err");
        assert (wb_adr_o === hold_adr) else value_mismatch("wb_adr_o", hold_adr, wb_adr_o);
        assert (wb_sel_o === hold_sel) else value_mismatch("wb_sel_o", hold_sel, wb_sel_o);
        assert (wb_we_o === hold_we) else value_mismatch("wb_we_o", hold_we, wb_we_o);
        assert (wb_dat_o === hold_dat) else value_mismatch("wb_dat_o", hold_dat, wb_dat_o);
      end
      assert (wb_cyc_o === wb_stb_o) else rule_broken("wb_cyc_o and wb_stb_o differ");
      stb_wait <= wb_stb_o && !wb_ack_i && !wb_err_i;
      hold_adr <= wb_adr_o;
      hold_sel <= wb_sel_o;
      hold_we  <= wb_we_o;
      hold_dat <= wb_dat_o;

      // End of one bus cycle
      if (wb_stb_o && (wb_ack_i || wb_err_i))
      begin
        assert (pending && (beats_seen < exp_beats))
          else rule_broken("bus cycle beyond the expected count");
        if (beats_seen < 2)
        begin
          assert (wb_adr_o === exp_adr[beats_seen])
            else value_mismatch("wb_adr_o", exp_adr[beats_seen], wb_adr_o);
          assert (wb_sel_o === exp_sel[beats_seen])
            else value_mismatch("wb_sel_o", exp_sel[beats_seen], wb_sel_o);
          assert (wb_we_o === exp_we) else value_mismatch("wb_we_o", exp_we, wb_we_o);
          for (int k = 0; k < 4; k++)
          begin
            if (exp_we && exp_sel[beats_seen][k])
            begin
              assert (wb_dat_o[k * 8 +: 8] === exp_wdat[k * 8 +: 8])
                else value_mismatch("wb_dat_o lane", exp_wdat[k * 8 +: 8], wb_dat_o[k * 8 +: 8]);
            end
          end
        end
        beats_seen <= beats_seen + 1;
      end

      // Response, or the handshake state around it
      if (rsp_valid_o)
      begin
        assert (pending) else rule_broken("response without an accepted request");
        assert (rsp_err_o === exp_err) else value_mismatch("rsp_err_o", exp_err, rsp_err_o);
        assert (rsp_addr_o === exp_addr) else value_mismatch("rsp_addr_o", exp_addr, rsp_addr_o);
        assert (beats_seen == exp_beats) else value_mismatch("bus cycles", exp_beats, beats_seen);
        if (!exp_err && !exp_we)
        begin
          assert (rsp_rdata_o === exp_rdata)
            else value_mismatch("rsp_rdata_o", exp_rdata, rsp_rdata_o);
        end
        pending  <= 1'b0;
        resp_cnt <= resp_cnt + 1;
      end
      else if (pending)
      begin
        assert (!req_ready_o) else rule_broken("req_ready_o high during an access");
      end
      else
      begin
        assert (req_ready_o && !wb_cyc_o) else rule_broken("DUT busy with no access accepted");
      end

      // Accepted request, model updated in order
      if (req_valid_i && req_ready_o)
      begin
        acc_n   = size_bytes(req_size_i);
        acc_off = req_addr_i[1:0];
        exp_addr   <= req_addr_i;
        exp_we     <= req_we_i;
        exp_err    <= req_addr_i[8];
        exp_beats  <= (req_addr_i[8] || (int'(acc_off) + acc_n <= 4)) ? 1 : 2;
        exp_adr[0] <= {req_addr_i[ADDR_W-1:2], 2'b00};
        exp_adr[1] <= {req_addr_i[ADDR_W-1:2], 2'b00} + 32'd4;  // Next word
        exp_sel[0] <= beat_lanes(acc_off, acc_n, 1'b0);
        exp_sel[1] <= beat_lanes(acc_off, acc_n, 1'b1);
        exp_wdat   <= lane_data(acc_off, req_wdata_i);
        exp_rdata  <= load_value(req_addr_i[7:0], acc_n, req_sign_ext_i);
        if (req_we_i && !req_addr_i[8])
          for (int k = 0; k < acc_n; k++)
            ref_mem[8'(req_addr_i[7:0] + k)] = req_wdata_i[k * 8 +: 8];
        pending    <= 1'b1;
        beats_seen <= 0;
        acc_cnt    <= acc_cnt + 1;
      end
    end
  end

  // Run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYC)
    begin
      $display("Timeout after %0d cycles, the DUT stopped finishing accesses", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Entered 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic issue(input logic we, input lsu_size_e size, input logic sext,
                       input logic [31:0] addr, input logic [31:0] wdata);
    req_valid_i    = 1'b1;
    req_we_i       = we;
    req_size_i     = size;
    req_sign_ext_i = sext;
    req_addr_i     = addr;
    req_wdata_i    = wdata;
    @(posedge clk);
    while (!req_ready_o)
      @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    @(posedge clk);
    while (pending || !req_ready_o)
      @(posedge clk);
    #1;
  endtask

  task automatic test_done(input string name, input int ops, input int errs_before);
    tests_run++;
    $display("test %s: %0d accesses, %0d errors", name, ops, err_cnt - errs_before);
  endtask

  initial
  begin
    int          e0;
    logic [31:0] addr;
    lsu_size_e   sz;
    seed           = 32'h9fc16173;
    clk            = 1'b0;
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_size_i     = LSU_BYTE;
    req_sign_ext_i = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    for (int a = 0; a < 256; a++)
      ref_mem[a] = 8'(a) ^ 8'ha5;  // Same fill as the slave
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;

    e0 = err_cnt;
    repeat (3) @(posedge clk);  // Idle right after reset
    #1;
    test_done("reset", 0, e0);

    // Every single beat size and offset, store then zero and sign extended loads
    e0 = err_cnt;
    for (int s = 0; s < 3; s++)
      for (int off = 0; off < 4; off++)
        if (off + size_bytes(lsu_size_e'(s)) <= 4)
        begin
          addr = 32'h20 * (s + 1) + off;
          issue(1'b1, lsu_size_e'(s), 1'b0, addr, $random(seed));
          issue(1'b0, lsu_size_e'(s), 1'b0, addr, 32'h0);
          issue(1'b0, lsu_size_e'(s), 1'b1, addr, 32'h0);
        end
    drain();
    test_done("aligned", N_ALIGNED, e0);

    // Word across a boundary at each offset, then the split halfword
    e0 = err_cnt;
    for (int c = 0; c < 4; c++)
    begin
      sz   = (c < 3) ? LSU_WORD : LSU_HALF;
      addr = (c < 3) ? 32'h80 + 9 * c + 1 : 32'hb3;
      issue(1'b1, sz, 1'b0, addr, $random(seed));
      issue(1'b0, sz, 1'b0, addr, 32'h0);
      issue(1'b0, sz, 1'b1, addr, 32'h0);
    end
    drain();
    test_done("misaligned", N_SPLIT, e0);

    e0 = err_cnt;
    issue(1'b0, LSU_BYTE, 1'b0, 32'h104, 32'h0);
    issue(1'b1, LSU_WORD, 1'b0, 32'h1f0, 32'hdeadbeef);
    issue(1'b0, LSU_WORD, 1'b1, 32'h1fd, 32'h0);       // First beat errs, no second
    issue(1'b1, LSU_HALF, 1'b0, 32'h1ff, 32'h0000a55a);
    drain();
    test_done("bus error", N_ERROR, e0);

    // Mixed traffic below the error range, no access wraps past 0xff
    e0 = err_cnt;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      sz   = lsu_size_e'($unsigned($random(seed)) % 3);
      addr = $unsigned($random(seed)) % 248;
      issue(1'($random(seed)), sz, 1'($random(seed)), addr, $random(seed));
    end
    drain();
    test_done("random", N_RANDOM, e0);

    assert (acc_cnt == resp_cnt) else rule_broken("accepted requests and responses differ");
    $display("tests %0d, accesses %0d, responses %0d, errors %0d",
             tests_run, acc_cnt, resp_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem
#(
  parameter int          ADDR_W = 32,
  parameter logic [31:0] SEED   = 32'h9fc16173
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [3:0]        sel_i,
  input  logic [31:0]       dat_i,
  output logic [31:0]       dat_o,
  output logic              ack_o,
  output logic              err_o
);

  logic [31:0] mem [64];   // 256 bytes, word index is adr_i[7:2]
  integer      seed;
  logic        busy;       // Cycle seen, counting wait states
  logic [1:0]  wait_left;

  // Every byte holds its own address, scrambled
  initial
  begin
    seed = SEED;
    for (int a = 0; a < 256; a++)
      mem[a / 4][(a % 4) * 8 +: 8] = 8'(a) ^ 8'ha5;
  end

  always @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_o     <= 1'b0;
      err_o     <= 1'b0;
      busy      <= 1'b0;
      wait_left <= 2'd0;
      dat_o     <= '0;
    end
    else
    begin
      ack_o <= 1'b0;  // Single cycle answers
      err_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o && !err_o)
      begin
        if (!busy)
        begin
          busy      <= 1'b1;
          wait_left <= 2'($random(seed));  // 0 to 3 extra cycles
        end
        else if (wait_left != 2'd0)
          wait_left <= wait_left - 2'd1;
        else
        begin
          busy <= 1'b0;
          if (adr_i[8])
            err_o <= 1'b1;                 // Error range
          else
          begin
            ack_o <= 1'b1;
            dat_o <= mem[adr_i[7:2]];
            if (we_i)
            begin
              for (int k = 0; k < 4; k++)
              begin
                if (sel_i[k])
                  mem[adr_i[7:2]][k * 8 +: 8] <= dat_i[k * 8 +: 8];
              end
            end
          end
        end
      end
    end
  end

endmodule
